/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_rrag
FILELIST  := all.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits non-zero on $$fatal, so make fails with it
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

/* all.f */
rtl/rrag_pkg.sv
rtl/ptc_generator.sv
rtl/pending_scoreboard.sv
rtl/gpr_file.sv
rtl/seg_file.sv
rtl/addr_gen.sv
rtl/issue_control.sv
rtl/rrag.sv
tests/tb_rrag.sv

/* rtl/addr_gen.sv */
module addr_gen
    import rrag_pkg::*;
(
    input  uop_t                         uop,
    input  logic [num_rd-1:0][31:0]      gpr_data,
    input  logic [num_rd-1:0][sel_w-1:0] seg_sel,
    output agen_t                        agen
);

    logic [31:0] base;
    logic [31:0] scaled_index;
    logic [31:0] offset;
    logic [31:0] seg1_base;
    logic [31:0] seg2_base;
    logic [31:0] last_byte;

    // ########################################
    // Effective address of the first operand
    // ########################################

    assign base         = uop.usereg2 ? gpr_data[1] : 32'h0;
    assign scaled_index = gpr_data[2] << uop.scale;

    // Without an index the offset is r2 whether or not usereg2 is set
    assign offset = uop.usereg3 ? base + scaled_index : gpr_data[1];

    // Segment selector shifted up by 16 acts as the segment base
    assign seg1_base = {seg_sel[0], 16'h0000};
    assign seg2_base = {seg_sel[1], 16'h0000};

    // ########################################
    // Addresses and end addresses
    // ########################################

    // Offset of the last byte of an access of opsize bytes
    assign last_byte = (32'd1 << uop.opsize) - 32'd1;

    always_comb begin
        agen.mem_addr1     = offset + uop.disp + seg1_base;
        agen.mem_addr2     = gpr_data[3] + seg2_base;
        agen.mem_addr1_end = agen.mem_addr1 + last_byte;
        agen.mem_addr2_end = agen.mem_addr2 + last_byte;
        agen.rep_num       = uop.is_rep ? gpr_data[3] : 32'h0;
    end

endmodule

/* rtl/gpr_file.sv */
module gpr_file
    import rrag_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue,
    input  gpr_wb_t                          wb,
    input  logic [num_rd-1:0][reg_idx_w-1:0] rd_addr,
    input  size_t                            rd_size,
    input  logic [num_regs-1:0]              dest_mask,
    input  logic [ptcid_w-1:0]               new_ptcid,
    input  logic                             ptc_clear,
    output logic [num_rd-1:0][31:0]          rd_data,
    output logic [num_rd-1:0]                rd_pending
);

    logic [num_regs-1:0][31:0] regs;

    // Byte and word writes leave the upper part of the register alone
    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (wb.valid) begin
            case (wb.size)
                size_byte: regs[wb.addr][7:0]  <= wb.data[7:0];
                size_word: regs[wb.addr][15:0] <= wb.data[15:0];
                default:   regs[wb.addr]       <= wb.data;
            endcase
        end
    end

    // Reads return the low opsize bytes, zero-extended
    always_comb begin
        for (int i = 0; i < num_rd; i++) begin
            case (rd_size)
                size_byte: rd_data[i] = {24'h000000, regs[rd_addr[i]][7:0]};
                size_word: rd_data[i] = {16'h0000, regs[rd_addr[i]][15:0]};
                default:   rd_data[i] = regs[rd_addr[i]];
            endcase
        end
    end

    pending_scoreboard u_sb (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .dest_mask  (dest_mask),
        .new_ptcid  (new_ptcid),
        .wb_valid   (wb.valid),
        .wb_addr    (wb.addr),
        .wb_ptcid   (wb.ptcid),
        .ptc_clear  (ptc_clear),
        .rd_addr    (rd_addr),
        .rd_pending (rd_pending)
    );

    // The writeback stage only ever produces byte, word or dword results
    wb_size_legal: assert property (
        @(posedge clk) disable iff (reset)
        wb.valid |-> wb.size != 2'd3
    ) else $error("writeback with size 3");

endmodule

/* rtl/issue_control.sv */
module issue_control
    import rrag_pkg::*;
(
    input  uop_t              uop,
    input  logic [num_rd-1:0] gpr_pending,
    input  logic              valid_in,
    input  logic              latch_empty,
    input  logic              fwd_stall,
    output logic              stall,
    output logic              issue
);

    logic mem1_stall;
    logic mem2_stall;

    // Only the registers that feed an address can hold the stage
    assign mem1_stall = (|uop.mem1_rw) &&
                        ((uop.usereg2 && gpr_pending[1]) || (uop.usereg3 && gpr_pending[2]));
    assign mem2_stall = ((|uop.mem2_rw) || uop.is_rep) && gpr_pending[3];

    always_comb begin
        stall = fwd_stall || mem1_stall || mem2_stall;
        issue = valid_in && !latch_empty && !stall;
    end

endmodule

/* rtl/pending_scoreboard.sv */
module pending_scoreboard
    import rrag_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue,
    input  logic [num_regs-1:0]              dest_mask,
    input  logic [ptcid_w-1:0]               new_ptcid,
    input  logic                             wb_valid,
    input  logic [reg_idx_w-1:0]             wb_addr,
    input  logic [ptcid_w-1:0]               wb_ptcid,
    input  logic                             ptc_clear,
    input  logic [num_rd-1:0][reg_idx_w-1:0] rd_addr,
    output logic [num_rd-1:0]                rd_pending
);

    logic [num_regs-1:0]              pending;
    logic [num_regs-1:0][ptcid_w-1:0] tag;

    // A new issue takes priority over a writeback that clears the same entry
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            tag     <= '0;
        end else begin
            for (int i = 0; i < num_regs; i++) begin
                if (ptc_clear) begin
                    pending[i] <= 1'b0;
                end else if (issue && dest_mask[i]) begin
                    pending[i] <= 1'b1;
                    tag[i]     <= new_ptcid;
                end else if (wb_valid && wb_addr == reg_idx_w'(i) && wb_ptcid == tag[i]) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_rd; i++) begin
            rd_pending[i] = pending[rd_addr[i]];
        end
    end

    // Results only come back for registers that some issued micro-op claimed
    wb_targets_pending: assert property (
        @(posedge clk) disable iff (reset)
        wb_valid |-> pending[wb_addr]
    ) else $error("writeback to register %0d which is not pending", wb_addr);

endmodule

/* rtl/ptc_generator.sv */
module ptc_generator
    import rrag_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    output logic [ptcid_w-1:0] ptcid
);

    // The current value tags the micro-op that sits in the stage now
    always_ff @(posedge clk) begin
        if (reset) begin
            ptcid <= '0;
        end else if (issue) begin
            // Wraps modulo 2^ptcid_w
            ptcid <= ptcid + 1'b1;
        end
    end

endmodule

/* rtl/rrag.sv */
module rrag
    import rrag_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  uop_t                         uop,
    input  logic                         valid_in,
    input  logic                         latch_empty,
    input  logic                         fwd_stall,
    input  gpr_wb_t                      gpr_wb,
    input  seg_wb_t                      seg_wb,
    input  logic                         ptc_clear,
    output logic                         valid_out,
    output logic                         stall,
    output logic [ptcid_w-1:0]           inst_ptcid,
    output logic [num_rd-1:0][31:0]      gpr_data,
    output logic [num_rd-1:0][sel_w-1:0] seg_sel,
    output logic [num_rd-1:0][lim_w-1:0] seg_lim,
    output agen_t                        agen
);

    logic              issue;
    logic [num_rd-1:0] gpr_pending;

    assign valid_out = issue;

    ptc_generator u_ptcgen (
        .clk   (clk),
        .reset (reset),
        .issue (issue),
        .ptcid (inst_ptcid)
    );

    gpr_file u_gpr (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .wb         (gpr_wb),
        .rd_addr    (uop.gpr_addr),
        .rd_size    (uop.opsize),
        .dest_mask  (uop.gpr_dest),
        .new_ptcid  (inst_ptcid),
        .ptc_clear  (ptc_clear),
        .rd_data    (gpr_data),
        .rd_pending (gpr_pending)
    );

    // Segment pending bits are tracked but do not enter the stall rule
    seg_file u_seg (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .wb         (seg_wb),
        .rd_addr    (uop.seg_addr),
        .dest_mask  (uop.seg_dest),
        .new_ptcid  (inst_ptcid),
        .ptc_clear  (ptc_clear),
        .sel        (seg_sel),
        .lim        (seg_lim),
        .rd_pending ()
    );

    addr_gen u_agen (
        .uop      (uop),
        .gpr_data (gpr_data),
        .seg_sel  (seg_sel),
        .agen     (agen)
    );

    issue_control u_issue (
        .uop         (uop),
        .gpr_pending (gpr_pending),
        .valid_in    (valid_in),
        .latch_empty (latch_empty),
        .fwd_stall   (fwd_stall),
        .stall       (stall),
        .issue       (issue)
    );

endmodule

/* rtl/rrag_pkg.sv */
package rrag_pkg;

    // ########################################
    // Sizes
    // ########################################

    localparam int num_regs    = 8;
    localparam int reg_idx_w   = 3;
    localparam int ptcid_w     = 7;
    localparam int num_rd      = 4;
    localparam int sel_w       = 16;
    localparam int lim_w       = 20;
    localparam int num_seg_lim = 6;

    // Operand and address size where an access covers 2^size bytes
    typedef logic [1:0] size_t;

    localparam size_t size_byte  = 2'd0;
    localparam size_t size_word  = 2'd1;
    localparam size_t size_dword = 2'd2;

    // Reset limits for ES, CS, SS, DS, FS and GS with ES in element 0
    localparam logic [num_seg_lim-1:0][lim_w-1:0] seg_lim_reset = {
        20'h00fff,
        20'h007ff,
        20'h03fff,
        20'h1ffff,
        20'h0ffff,
        20'h04fff
    };

    // ########################################
    // Structs
    // ########################################

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] addr;
        size_t                size;
        logic [31:0]          data;
        logic [ptcid_w-1:0]   ptcid;
    } gpr_wb_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] addr;
        logic [sel_w-1:0]     selector;
        logic [ptcid_w-1:0]   ptcid;
    } seg_wb_t;

    // Read slot 0 is the plain operand, 1 the base, 2 the index, 3 the second address
    typedef struct packed {
        logic [num_rd-1:0][reg_idx_w-1:0] gpr_addr;
        logic [num_rd-1:0][reg_idx_w-1:0] seg_addr;
        size_t                            opsize;
        logic                             usereg2;
        logic                             usereg3;
        logic [1:0]                       scale;
        logic [31:0]                      disp;
        logic [1:0]                       mem1_rw;
        logic [1:0]                       mem2_rw;
        logic                             is_rep;
        logic [num_regs-1:0]              gpr_dest;
        logic [num_regs-1:0]              seg_dest;
    } uop_t;

    typedef struct packed {
        logic [31:0] mem_addr1;
        logic [31:0] mem_addr1_end;
        logic [31:0] mem_addr2;
        logic [31:0] mem_addr2_end;
        logic [31:0] rep_num;
    } agen_t;

endpackage

/* rtl/seg_file.sv */
module seg_file
    import rrag_pkg::*;
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             issue,
    input  seg_wb_t                          wb,
    input  logic [num_rd-1:0][reg_idx_w-1:0] rd_addr,
    input  logic [num_regs-1:0]              dest_mask,
    input  logic [ptcid_w-1:0]               new_ptcid,
    input  logic                             ptc_clear,
    output logic [num_rd-1:0][sel_w-1:0]     sel,
    output logic [num_rd-1:0][lim_w-1:0]     lim,
    output logic [num_rd-1:0]                rd_pending
);

    logic [num_regs-1:0][sel_w-1:0] sel_q;
    logic [num_regs-1:0][lim_w-1:0] lim_q;
    logic [num_regs-1:0][lim_w-1:0] lim_init;

    // The two upper segments have no reset limit
    assign lim_init = {{((num_regs - num_seg_lim) * lim_w){1'b0}}, seg_lim_reset};

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_q <= '0;
            lim_q <= lim_init;
        end else if (wb.valid) begin
            sel_q[wb.addr] <= wb.selector;
        end
    end

    always_comb begin
        for (int i = 0; i < num_rd; i++) begin
            sel[i] = sel_q[rd_addr[i]];
            lim[i] = lim_q[rd_addr[i]];
        end
    end

    pending_scoreboard u_sb (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .dest_mask  (dest_mask),
        .new_ptcid  (new_ptcid),
        .wb_valid   (wb.valid),
        .wb_addr    (wb.addr),
        .wb_ptcid   (wb.ptcid),
        .ptc_clear  (ptc_clear),
        .rd_addr    (rd_addr),
        .rd_pending (rd_pending)
    );

endmodule

/* tests/tb_rrag.sv */
module tb_rrag
    import rrag_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // The watchdog limit is built from rough cycle counts per test
    localparam int cycles_t1 = 8 * 3 * 6;
    localparam int cycles_t2 = 6 * 4 + 32 * 2;
    localparam int cycles_t3 = 3 * 12 + 12;
    localparam int cycles_t4 = 12;
    localparam int cycles_t5 = 4 * 6 + 8;
    localparam int cycles_t6 = 200 * 12;
    localparam int watchdog_cycles = 16 + cycles_t1 + cycles_t2 + cycles_t3 + cycles_t4
                                     + cycles_t5 + cycles_t6 + 500;

    logic clk;
    logic reset;
    uop_t uop;
    logic valid_in;
    logic latch_empty;
    logic fwd_stall;
    gpr_wb_t gpr_wb;
    seg_wb_t seg_wb;
    logic ptc_clear;
    logic valid_out;
    logic stall;
    logic [ptcid_w-1:0] inst_ptcid;
    logic [num_rd-1:0][31:0] gpr_data;
    logic [num_rd-1:0][sel_w-1:0] seg_sel;
    logic [num_rd-1:0][lim_w-1:0] seg_lim;
    agen_t agen;

    // Reference model state
    logic [31:0] m_gpr[num_regs];
    logic [sel_w-1:0] m_sel[num_regs];
    logic m_gpend[num_regs];
    logic [ptcid_w-1:0] m_gtag[num_regs];
    logic [ptcid_w-1:0] m_id;
    logic [31:0] lcg_state;

    rrag u_dut (
        .clk         (clk),
        .reset       (reset),
        .uop         (uop),
        .valid_in    (valid_in),
        .latch_empty (latch_empty),
        .fwd_stall   (fwd_stall),
        .gpr_wb      (gpr_wb),
        .seg_wb      (seg_wb),
        .ptc_clear   (ptc_clear),
        .valid_out   (valid_out),
        .stall       (stall),
        .inst_ptcid  (inst_ptcid),
        .gpr_data    (gpr_data),
        .seg_sel     (seg_sel),
        .seg_lim     (seg_lim),
        .agen        (agen)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run timed out before all tests finished");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ########################################
    // Compare tasks
    // ########################################

    task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
        $display("Done: errors found");
        $fatal(1, "value check failed");
    endtask

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) report_mismatch(name, exp, act);
    endtask

    task automatic check_sel(string name, logic [sel_w-1:0] exp, logic [sel_w-1:0] act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_lim(string name, logic [lim_w-1:0] exp, logic [lim_w-1:0] act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic check_ptcid(string name, logic [ptcid_w-1:0] exp, logic [ptcid_w-1:0] act);
        if (exp !== act) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    // ########################################
    // Model
    // ########################################

    function automatic logic [31:0] model_read(logic [2:0] a, size_t sz);
        case (sz)
            2'd0: return {24'h0, m_gpr[a][7:0]};
            2'd1: return {16'h0, m_gpr[a][15:0]};
            default: return m_gpr[a];
        endcase
    endfunction

    function automatic agen_t model_agen(uop_t u);
        logic [31:0] r[4];
        logic [31:0] off;
        logic [31:0] nbytes;
        agen_t a;
        for (int k = 0; k < 4; k++) r[k] = model_read(u.gpr_addr[k], u.opsize);
        nbytes = 32'd1 << u.opsize;
        if (u.usereg3) off = (u.usereg2 ? r[1] : 32'h0) + (r[2] << u.scale);
        else off = r[1];
        a.mem_addr1 = off + u.disp + 32'(m_sel[u.seg_addr[0]]) * 32'h10000;
        a.mem_addr2 = r[3] + 32'(m_sel[u.seg_addr[1]]) * 32'h10000;
        a.mem_addr1_end = a.mem_addr1 + nbytes - 32'd1;
        a.mem_addr2_end = a.mem_addr2 + nbytes - 32'd1;
        a.rep_num = u.is_rep ? r[3] : 32'h0;
        return a;
    endfunction

    function automatic logic model_stall(uop_t u);
        logic s1;
        logic s2;
        s1 = (u.mem1_rw != 0) && ((u.usereg2 && m_gpend[u.gpr_addr[1]]) ||
                                  (u.usereg3 && m_gpend[u.gpr_addr[2]]));
        s2 = ((u.mem2_rw != 0) || u.is_rep) && m_gpend[u.gpr_addr[3]];
        return s1 || s2;
    endfunction

    // ########################################
    // Drivers
    // ########################################

    task automatic issue_uop(uop_t u);
        @(posedge clk);
        uop <= u;
        valid_in <= 1'b1;
        @(negedge clk);
        check_bit("valid_out", 1'b1, valid_out);
        check_ptcid("inst_ptcid", m_id, inst_ptcid);
        @(posedge clk);
        valid_in <= 1'b0;
        uop <= '0;
        for (int i = 0; i < num_regs; i++) begin
            if (u.gpr_dest[i]) begin
                m_gpend[i] = 1'b1;
                m_gtag[i] = m_id;
            end
        end
        m_id = m_id + 1'b1;
    endtask

    // The writeback is driven just after a rising edge and lands on the next one
    task automatic present_gpr_wb(logic [2:0] a, size_t sz, logic [31:0] d,
                                  logic [ptcid_w-1:0] id);
        gpr_wb <= '{valid: 1'b1, addr: a, size: sz, data: d, ptcid: id};
        @(posedge clk);
        gpr_wb <= '0;
        case (sz)
            2'd0: m_gpr[a][7:0] = d[7:0];
            2'd1: m_gpr[a][15:0] = d[15:0];
            default: m_gpr[a] = d;
        endcase
        if (id == m_gtag[a]) m_gpend[a] = 1'b0;
    endtask

    task automatic write_gpr(logic [2:0] a, size_t sz, logic [31:0] d);
        uop_t u;
        u = '0;
        u.gpr_dest = 8'(1) << a;
        issue_uop(u);
        present_gpr_wb(a, sz, d, m_gtag[a]);
    endtask

    task automatic write_seg(logic [2:0] a, logic [sel_w-1:0] s);
        uop_t u;
        logic [ptcid_w-1:0] id;
        u = '0;
        u.seg_dest = 8'(1) << a;
        id = m_id;
        issue_uop(u);
        seg_wb <= '{valid: 1'b1, addr: a, selector: s, ptcid: id};
        @(posedge clk);
        seg_wb <= '0;
        m_sel[a] = s;
    endtask

    task automatic read_check(uop_t u);
        agen_t e;
        @(posedge clk);
        uop <= u;
        valid_in <= 1'b0;
        @(negedge clk);
        e = model_agen(u);
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("gpr_data[%0d]", k), model_read(u.gpr_addr[k], u.opsize),
                       gpr_data[k]);
            check_sel($sformatf("seg_sel[%0d]", k), m_sel[u.seg_addr[k]], seg_sel[k]);
        end
        check_word("mem_addr1", e.mem_addr1, agen.mem_addr1);
        check_word("mem_addr1_end", e.mem_addr1_end, agen.mem_addr1_end);
        check_word("mem_addr2", e.mem_addr2, agen.mem_addr2);
        check_word("mem_addr2_end", e.mem_addr2_end, agen.mem_addr2_end);
        check_word("rep_num", e.rep_num, agen.rep_num);
        check_bit("stall", model_stall(u), stall);
    endtask

    task automatic probe_stall(uop_t u);
        @(posedge clk);
        uop <= u;
        valid_in <= 1'b0;
        @(negedge clk);
        check_bit("stall", model_stall(u), stall);
    endtask

    // ########################################
    // Tests
    // ########################################

    // Dword first, so the narrower writes must keep the upper bits
    task automatic test_sized_rw();
        uop_t u;
        for (int r = 0; r < num_regs; r++) begin
            for (int s = 0; s < 3; s++) begin
                write_gpr(3'(r), size_t'(2 - s), lcg_next());
                for (int rs = 0; rs < 3; rs++) begin
                    u = '0;
                    u.gpr_addr = {4{3'(r)}};
                    u.opsize = size_t'(rs);
                    read_check(u);
                end
            end
        end
    endtask

    task automatic test_addr_arith();
        uop_t u;
        write_gpr(3'd1, size_dword, 32'h1000_2000);
        write_gpr(3'd2, size_dword, 32'h0000_0130);
        write_gpr(3'd3, size_dword, 32'hffff_fff0);
        write_seg(3'd3, 16'h0123);
        write_seg(3'd4, 16'hf00d);
        for (int sc = 0; sc < 4; sc++) begin
            for (int c = 0; c < 8; c++) begin
                u = '0;
                u.gpr_addr[1] = 3'd1;
                u.gpr_addr[2] = 3'd2;
                u.gpr_addr[3] = 3'd3;
                u.seg_addr[0] = 3'd3;
                u.seg_addr[1] = 3'd4;
                u.scale = 2'(sc);
                u.usereg2 = c[0];
                u.usereg3 = c[1];
                u.is_rep = c[2];
                u.opsize = c[2] ? size_word : size_dword;
                u.disp = 32'h0000_8004;
                read_check(u);
            end
        end
    endtask

    task automatic test_scoreboard();
        uop_t u;
        uop_t rd;
        for (int slot = 1; slot < 4; slot++) begin
            u = '0;
            u.gpr_dest = 8'h20;
            issue_uop(u);
            rd = '0;
            rd.gpr_addr[slot] = 3'd5;
            rd.opsize = size_dword;
            rd.mem1_rw = (slot < 3) ? 2'd1 : 2'd0;
            rd.mem2_rw = (slot == 3) ? 2'd2 : 2'd0;
            rd.usereg2 = (slot == 1);
            rd.usereg3 = (slot == 2);
            probe_stall(rd);
            check_bit("stall", 1'b1, stall);
            @(posedge clk);
            present_gpr_wb(3'd5, size_dword, lcg_next(), m_gtag[5] + 1'b1);
            @(negedge clk);
            check_bit("stall", 1'b1, stall);
            @(posedge clk);
            present_gpr_wb(3'd5, size_dword, lcg_next(), m_gtag[5]);
            @(negedge clk);
            check_bit("stall", 1'b0, stall);
        end
        u = '0;
        u.gpr_dest = 8'h0e;
        issue_uop(u);
        rd = '0;
        rd.gpr_addr = {3'd3, 3'd2, 3'd1, 3'd0};
        rd.usereg2 = 1'b1;
        rd.usereg3 = 1'b1;
        rd.mem1_rw = 2'd3;
        probe_stall(rd);
        check_bit("stall", 1'b1, stall);
        @(posedge clk);
        ptc_clear <= 1'b1;
        @(posedge clk);
        ptc_clear <= 1'b0;
        for (int i = 0; i < num_regs; i++) m_gpend[i] = 1'b0;
        rd.mem2_rw = 2'd1;
        probe_stall(rd);
        check_bit("stall", 1'b0, stall);
    endtask

    task automatic test_id_issue();
        @(posedge clk);
        uop <= '0;
        valid_in <= 1'b1;
        latch_empty <= 1'b1;
        @(negedge clk);
        check_bit("valid_out", 1'b0, valid_out);
        @(posedge clk);
        latch_empty <= 1'b0;
        fwd_stall <= 1'b1;
        @(negedge clk);
        check_ptcid("inst_ptcid", m_id, inst_ptcid);
        check_bit("stall", 1'b1, stall);
        check_bit("valid_out", 1'b0, valid_out);
        @(posedge clk);
        fwd_stall <= 1'b0;
        @(negedge clk);
        check_ptcid("inst_ptcid", m_id, inst_ptcid);
        check_bit("valid_out", 1'b1, valid_out);
        @(posedge clk);
        valid_in <= 1'b0;
        m_id = m_id + 1'b1;
        @(negedge clk);
        check_ptcid("inst_ptcid", m_id, inst_ptcid);
    endtask

    task automatic test_segments();
        uop_t u;
        logic [lim_w-1:0] exp_lim;
        for (int g = 0; g < 2; g++) begin
            u = '0;
            for (int k = 0; k < 4; k++) u.seg_addr[k] = 3'(g * 4 + k);
            read_check(u);
            for (int k = 0; k < 4; k++) begin
                exp_lim = (g * 4 + k < num_seg_lim) ? seg_lim_reset[g * 4 + k] : '0;
                check_lim($sformatf("seg_lim[%0d]", k), exp_lim, seg_lim[k]);
            end
        end
        write_seg(3'd0, 16'h1234);
        write_seg(3'd7, 16'hbeef);
        u = '0;
        u.seg_addr = {3'd1, 3'd2, 3'd7, 3'd0};
        u.opsize = size_dword;
        read_check(u);
    endtask

    task automatic test_random();
        uop_t u;
        for (int n = 0; n < 200; n++) begin
            write_gpr(3'(lcg_next() >> 16), size_dword, lcg_next());
            write_gpr(3'(lcg_next() >> 16), size_dword, lcg_next());
            write_seg(3'(lcg_next() >> 16), 16'(lcg_next() >> 8));
            u = '0;
            for (int k = 0; k < 4; k++) begin
                u.gpr_addr[k] = 3'(lcg_next() >> 16);
                u.seg_addr[k] = 3'(lcg_next() >> 16);
            end
            u.opsize = size_t'((lcg_next() >> 16) % 3);
            u.usereg2 = 1'(lcg_next() >> 31);
            u.usereg3 = 1'(lcg_next() >> 31);
            u.scale = 2'(lcg_next() >> 20);
            u.disp = lcg_next();
            u.mem1_rw = 2'(lcg_next() >> 20);
            u.mem2_rw = 2'(lcg_next() >> 20);
            u.is_rep = 1'(lcg_next() >> 31);
            read_check(u);
        end
    endtask

    initial begin
        lcg_state = 32'd38304;
        m_id = '0;
        for (int i = 0; i < num_regs; i++) begin
            m_gpr[i] = '0;
            m_sel[i] = '0;
            m_gpend[i] = 1'b0;
            m_gtag[i] = '0;
        end
        reset = 1'b1;
        uop = '0;
        valid_in = 1'b0;
        latch_empty = 1'b0;
        fwd_stall = 1'b0;
        gpr_wb = '0;
        seg_wb = '0;
        ptc_clear = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("valid_out", 1'b0, valid_out);
        check_bit("stall", 1'b0, stall);
        check_ptcid("inst_ptcid", 7'd0, inst_ptcid);
        test_segments();
        test_sized_rw();
        test_addr_arith();
        test_scoreboard();
        test_id_issue();
        test_random();
        $display("Done: no errors");
        $finish;
    end

endmodule
